/* hw/l1d_geom_pkg.sv */
// L1 data cache geometry
// Address split, line layout and byte enable types for the direct-mapped cache

package l1d_geom_pkg;

  // ======================================================================
  // Sizes
  // ======================================================================
  localparam int ADDR_BITS   = 32;
  localparam int WORD_BITS   = 32;
  localparam int OFFSET_BITS = 4;   // 16 byte lines
  localparam int INDEX_BITS  = 6;
  localparam int TAG_BITS    = 22;  // ADDR_BITS - INDEX_BITS - OFFSET_BITS
  localparam int LINE_WORDS  = 4;
  localparam int LINE_BYTES  = 16;
  localparam int NUM_LINES   = 64;

  // ======================================================================
  // Types
  // ======================================================================

  // Byte address as seen by the cache
  typedef struct packed {
    logic [TAG_BITS-1:0]    tag;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;
  } l1d_addr_t;

  // Word 0 sits in the low 32 bits
  typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] l1d_line_t;

  // One enable per byte of a line
  typedef logic [LINE_BYTES-1:0] l1d_be_t;

endpackage

/* hw/l1d_bus_pkg.sv */
// L1 data cache bus types
// Core request, memory request and line store write formats

package l1d_bus_pkg;

  import l1d_geom_pkg::*;

  // Access size, same codes as the core's load/store type field
  typedef enum logic [2:0] {
    ACC_BYTE = 3'd0,
    ACC_HALF = 3'd1,
    ACC_WORD = 3'd2
  } acc_size_e;

  // Request from the core
  typedef struct packed {
    logic                 write;
    l1d_addr_t            addr;
    logic [WORD_BITS-1:0] wdata;
    acc_size_e            size;
  } core_req_t;

  // Request to memory, req is a one cycle strobe
  typedef struct packed {
    logic                 req;
    logic                 write;
    logic [ADDR_BITS-1:0] addr;
    logic [WORD_BITS-1:0] wdata;
    acc_size_e            size;
  } mem_req_t;

  // Byte-masked store into the line store
  typedef struct packed {
    logic                  en;
    logic [INDEX_BITS-1:0] index;
    l1d_be_t               be;
    l1d_line_t             data;
  } line_wr_t;

endpackage

/* hw/l1d_line_store.sv */
// L1 data line store
// Tag, data and valid arrays with a registered lookup port, a refill port and a byte write port

`timescale 1ns/1ps

module l1d_line_store
  import l1d_geom_pkg::*, l1d_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INDEX_BITS-1:0] lookup_index,
  output logic [TAG_BITS-1:0]   rd_tag,
  output logic                  rd_valid,
  output l1d_line_t             rd_line,
  input  logic                  fill_we,
  input  logic [INDEX_BITS-1:0] fill_index,
  input  logic [TAG_BITS-1:0]   fill_tag,
  input  l1d_line_t             fill_line,
  input  line_wr_t              line_wr
);

  l1d_line_t             data_mem [NUM_LINES];
  logic [TAG_BITS-1:0]   tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0]  valid_q;

  // ======================================================================
  // Data and tag arrays
  // ======================================================================
  always_ff @(posedge clk)
  begin
    rd_line <= data_mem[lookup_index];  // old data on a same-cycle write
    rd_tag  <= tag_mem[lookup_index];
    if (fill_we)
    begin
      data_mem[fill_index] <= fill_line;
      tag_mem[fill_index]  <= fill_tag;
    end
    else if (line_wr.en)
    begin
      for (int b = 0; b < LINE_BYTES; b++)
      begin
        if (line_wr.be[b])
          data_mem[line_wr.index][b/4][(b%4)*8 +: 8] <= line_wr.data[b/4][(b%4)*8 +: 8];
      end
    end
  end

  // ======================================================================
  // Valid bits
  // ======================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q  <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= valid_q[lookup_index];
      if (fill_we)
        valid_q[fill_index] <= 1'b1;
    end
  end

  // Refill and store come from different controller states
  a_no_fill_store_clash: assert property (
    @(posedge clk) disable iff (rst) !(fill_we && line_wr.en)
  );

endmodule

/* hw/l1d_store_merge.sv */
// L1 data store merge
// Turns a core store into byte enables and lane-aligned data for one cache line

`timescale 1ns/1ps

module l1d_store_merge
  import l1d_geom_pkg::*, l1d_bus_pkg::*;
(
  input  logic      store_en,
  input  core_req_t store_req,
  output line_wr_t  line_wr
);

  logic [OFFSET_BITS-3:0] word_sel;
  logic [1:0]             lane;
  logic [3:0]             word_be;
  logic [WORD_BITS-1:0]   word_data;

  assign word_sel = store_req.addr.offset[OFFSET_BITS-1:2];
  assign lane     = store_req.addr.offset[1:0];

  // Replicate the data so every lane carries it, the enables pick the bytes
  always_comb
  begin
    case (store_req.size)
      ACC_BYTE:
      begin
        word_be   = 4'b0001 << lane;
        word_data = {4{store_req.wdata[7:0]}};
      end
      ACC_HALF:
      begin
        word_be   = 4'b0011 << lane;
        word_data = {2{store_req.wdata[15:0]}};
      end
      default:
      begin
        word_be   = 4'b1111;
        word_data = store_req.wdata;
      end
    endcase
  end

  assign line_wr.en    = store_en;
  assign line_wr.index = store_req.addr.index;
  assign line_wr.be    = {12'd0, word_be} << {word_sel, 2'b00};
  assign line_wr.data  = {LINE_WORDS{word_data}};

  // Misaligned stores are not supported
  always_comb
  begin
    if (store_en)
      a_store_aligned: assert final (
        (store_req.size == ACC_BYTE) ||
        (store_req.size == ACC_HALF && !lane[0]) ||
        (store_req.size == ACC_WORD && lane == 2'b00)
      );
  end

endmodule

/* hw/l1d_mem_seq.sv */
// L1 data memory sequencer
// Runs a four word line refill or a single write-through on the memory port

`timescale 1ns/1ps

module l1d_mem_seq
  import l1d_geom_pkg::*, l1d_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fill_start,
  input  logic                  wr_start,
  input  core_req_t             req_q,
  input  logic                  d_wait,
  input  logic [WORD_BITS-1:0]  d_out,
  output mem_req_t              mem_out,
  output logic                  fill_we,
  output logic [INDEX_BITS-1:0] fill_index,
  output logic [TAG_BITS-1:0]   fill_tag,
  output l1d_line_t             fill_line,
  output logic                  seq_done
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_REQ,   // strobe cycle, d_wait not yet up
    SEQ_WAIT
  } seq_state_e;

  seq_state_e state;
  logic       is_fill;
  logic [1:0] cnt;
  l1d_line_t  line_q;
  l1d_addr_t  cur_addr;
  logic       beat_done;

  assign cur_addr   = l1d_addr_t'(mem_out.addr);
  assign beat_done  = (state == SEQ_WAIT) && !d_wait;
  assign fill_index = cur_addr.index;
  assign fill_tag   = cur_addr.tag;
  assign fill_line  = line_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= SEQ_IDLE;
      mem_out  <= '0;
      is_fill  <= 1'b0;
      cnt      <= '0;
      fill_we  <= 1'b0;
      seq_done <= 1'b0;
    end
    else
    begin
      mem_out.req <= 1'b0;
      fill_we     <= 1'b0;
      seq_done    <= 1'b0;
      case (state)
        SEQ_IDLE:
        begin
          if (fill_start)
          begin
            mem_out <= '{req: 1'b1, write: 1'b0, wdata: req_q.wdata, size: ACC_WORD,
                         addr: {req_q.addr.tag, req_q.addr.index, {OFFSET_BITS{1'b0}}}};
            is_fill <= 1'b1;
            cnt     <= '0;
            state   <= SEQ_REQ;
          end
          else if (wr_start)
          begin
            mem_out <= '{req: 1'b1, write: 1'b1, addr: req_q.addr, wdata: req_q.wdata,
                         size: req_q.size};
            is_fill <= 1'b0;
            state   <= SEQ_REQ;
          end
        end
        SEQ_REQ: state <= SEQ_WAIT;
        default:
        begin
          if (beat_done && (!is_fill || cnt == 2'(LINE_WORDS-1)))
          begin
            fill_we  <= is_fill;
            seq_done <= 1'b1;
            state    <= SEQ_IDLE;
          end
          else if (beat_done)
          begin
            cnt          <= cnt + 2'd1;
            mem_out.req  <= 1'b1;  // next word of the line
            mem_out.addr <= mem_out.addr + ADDR_BITS'(WORD_BITS/8);
            state        <= SEQ_REQ;
          end
        end
      endcase
    end
  end

  // Words arrive from the line base, so the first ends up in word 0
  always_ff @(posedge clk)
  begin
    if (beat_done && is_fill)
      line_q <= {d_out, line_q[LINE_WORDS-1:1]};
  end

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    (fill_start || wr_start) |-> (state == SEQ_IDLE) && !(fill_start && wr_start)
  );

endmodule

/* hw/l1d_ctrl.sv */
// L1 data cache controller
// Captures core requests, checks the tag and steers hits, refills and write-throughs

`timescale 1ns/1ps

module l1d_ctrl
  import l1d_geom_pkg::*, l1d_bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  core_req,
  input  core_req_t             core_in,
  output logic                  core_wait,
  output logic [WORD_BITS-1:0]  core_out,
  output logic [INDEX_BITS-1:0] lookup_index,
  input  logic [TAG_BITS-1:0]   rd_tag,
  input  logic                  rd_valid,
  input  l1d_line_t             rd_line,
  output core_req_t             store_req,
  output logic                  store_en,
  output logic                  fill_start,
  output logic                  wr_start,
  output core_req_t             req_q,
  input  logic                  seq_done,
  input  l1d_line_t             fill_line
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_RESULT,
    S_FILL,
    S_WRITE
  } ctrl_state_e;

  ctrl_state_e            state;
  ctrl_state_e            state_d;
  logic                   hit;
  logic [OFFSET_BITS-3:0] word_sel;

  // ======================================================================
  // Lookup and hit check
  // ======================================================================

  // Index goes out before the capture edge so tags are ready in S_LOOKUP
  assign lookup_index = (state == S_IDLE) ? core_in.addr.index : req_q.addr.index;

  assign hit      = rd_valid && (rd_tag == req_q.addr.tag);
  assign word_sel = req_q.addr.offset[OFFSET_BITS-1:2];

  assign core_wait  = (state != S_IDLE);
  assign fill_start = (state == S_LOOKUP) && !req_q.write && !hit;
  assign wr_start   = (state == S_LOOKUP) && req_q.write;  // write-through on hit and miss
  assign store_en   = wr_start && hit;                     // no allocate on write miss
  assign store_req  = req_q;

  // ======================================================================
  // State machine
  // ======================================================================
  always_comb
  begin
    state_d = state;
    case (state)
      S_IDLE:
      begin
        if (core_req)
          state_d = S_LOOKUP;
      end
      S_LOOKUP:
      begin
        if (req_q.write)
          state_d = S_WRITE;
        else if (hit)
          state_d = S_RESULT;
        else
          state_d = S_FILL;
      end
      S_RESULT: state_d = S_IDLE;
      S_FILL, S_WRITE:
      begin
        if (seq_done)
          state_d = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= S_IDLE;
      core_out <= '0;
    end
    else
    begin
      state <= state_d;
      if (state == S_RESULT)
        core_out <= rd_line[word_sel];
      else if (state == S_FILL && seq_done)
        core_out <= fill_line[word_sel];   // requested word of the new line
    end
  end

  // Request held for the whole access
  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && core_req)
      req_q <= core_in;
  end

  a_state_known: assert property (
    @(posedge clk) disable iff (rst) !$isunknown(state)
  );

endmodule

/* hw/l1d_cache.sv */
// L1 data cache top
// Direct-mapped write-through cache, 64 lines of 16 bytes

`timescale 1ns/1ps

module l1d_cache
  import l1d_geom_pkg::*, l1d_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 core_req,
  input  core_req_t            core_in,
  output logic                 core_wait,
  output logic [WORD_BITS-1:0] core_out,
  input  logic                 d_wait,
  input  logic [WORD_BITS-1:0] d_out,
  output mem_req_t             mem_out
);

  logic [INDEX_BITS-1:0] lookup_index;
  logic [TAG_BITS-1:0]   rd_tag;
  logic                  rd_valid;
  l1d_line_t             rd_line;
  core_req_t             store_req;
  logic                  store_en;
  logic                  fill_start;
  logic                  wr_start;
  core_req_t             req_q;
  logic                  seq_done;
  logic                  fill_we;
  logic [INDEX_BITS-1:0] fill_index;
  logic [TAG_BITS-1:0]   fill_tag;
  l1d_line_t             fill_line;
  line_wr_t              line_wr;

  l1d_ctrl i_l1d_ctrl (
    .clk, .rst, .core_req, .core_in, .core_wait, .core_out,
    .lookup_index, .rd_tag, .rd_valid, .rd_line,
    .store_req, .store_en, .fill_start, .wr_start, .req_q,
    .seq_done, .fill_line
  );

  l1d_mem_seq i_l1d_mem_seq (
    .clk, .rst, .fill_start, .wr_start, .req_q, .d_wait, .d_out,
    .mem_out, .fill_we, .fill_index, .fill_tag, .fill_line, .seq_done
  );

  l1d_store_merge i_l1d_store_merge (
    .store_en, .store_req, .line_wr
  );

  l1d_line_store i_l1d_line_store (
    .clk, .rst, .lookup_index, .rd_tag, .rd_valid, .rd_line,
    .fill_we, .fill_index, .fill_tag, .fill_line, .line_wr
  );

endmodule

/* verif/tb_l1d_cache.sv */
// L1 data cache testbench
// Replays the stim file against the cache with a randomized-latency memory model

`timescale 1ns/1ps

module tb_l1d_cache
  import l1d_geom_pkg::*, l1d_bus_pkg::*;
();

  localparam int MAX_OPS   = 64;
  localparam int OP_FIELDS = 6;

  logic                 clk;
  logic                 rst;
  logic                 core_req;
  core_req_t            core_in;
  logic                 core_wait;
  logic [WORD_BITS-1:0] core_out;
  logic                 d_wait;
  logic [WORD_BITS-1:0] d_out;
  mem_req_t             mem_out;

  logic [31:0]          stim_words [MAX_OPS*OP_FIELDS];
  logic [31:0]          mem_words [logic [29:0]];   // sparse backing memory
  logic [TAG_BITS-1:0]  line_tag [NUM_LINES];       // expected cache contents
  logic                 line_valid [NUM_LINES];

  int          error_count = 0;
  int          check_count = 0;
  int          op_count = 0;
  int unsigned req_count = 0;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 100;
  logic        mem_busy = 1'b0;
  int          wait_left = 0;
  mem_req_t    cur_req;
  logic [31:0] last_load = '0;   // core_out is cleared by reset

  l1d_cache i_l1d_cache (
    .clk       (clk),
    .rst       (rst),
    .core_req  (core_req),
    .core_in   (core_in),
    .core_wait (core_wait),
    .core_out  (core_out),
    .d_wait    (d_wait),
    .d_out     (d_out),
    .mem_out   (mem_out)
  );

  always #20 clk = ~clk;

  // ====================================================================
  // Checks and memory helpers
  // ====================================================================
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] mem_read(input logic [29:0] word_addr);
    if (mem_words.exists(word_addr))
      return mem_words[word_addr];
    return {2'b00, word_addr} ^ 32'hc0de_0000;   // untouched words
  endfunction

  task automatic mem_write(input mem_req_t req);
    logic [31:0] word;
    word = mem_read(req.addr[31:2]);
    case (req.size)
      ACC_BYTE: word[req.addr[1:0]*8 +: 8] = req.wdata[7:0];
      ACC_HALF: word[req.addr[1]*16 +: 16] = req.wdata[15:0];
      default:  word = req.wdata;
    endcase
    mem_words[req.addr[31:2]] = word;
  endtask

  // ====================================================================
  // Memory model holding d_wait for 1 to 4 cycles per access
  // ====================================================================
  always @(negedge clk)
  begin
    if (rst)
    begin
      mem_busy = 1'b0;
      d_wait   = 1'b0;
    end
    else if (mem_busy)
    begin
      if (wait_left > 0)
      begin
        d_wait = 1'b1;
        wait_left--;
      end
      else
      begin
        d_wait = 1'b0;
        if (cur_req.write)
          mem_write(cur_req);
        else
          d_out = mem_read(cur_req.addr[31:2]);   // valid in the cycle d_wait drops
        mem_busy = 1'b0;
      end
    end
    else if (mem_out.req)
    begin
      req_count++;
      cur_req   = mem_out;
      wait_left = $urandom_range(4, 1);
      mem_busy  = 1'b1;
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // ====================================================================
  // One operation from the stim file
  // ====================================================================
  task automatic run_op(input int idx);
    logic [31:0]           id;
    logic [31:0]           op;
    logic [31:0]           addr;
    logic [31:0]           size;
    logic [31:0]           data;
    logic [31:0]           exp;
    logic [INDEX_BITS-1:0] index;
    logic                  hit;
    int unsigned           pulses_before;
    int                    errors_before;
    int                    wait_cycles;
    id    = stim_words[idx*OP_FIELDS];
    op    = stim_words[idx*OP_FIELDS+1];
    addr  = stim_words[idx*OP_FIELDS+2];
    size  = stim_words[idx*OP_FIELDS+3];
    data  = stim_words[idx*OP_FIELDS+4];
    exp   = stim_words[idx*OP_FIELDS+5];
    index = addr[9:4];
    hit   = line_valid[index] && (line_tag[index] == addr[31:10]);
    errors_before = error_count;
    pulses_before = req_count;

    @(negedge clk);
    core_req = 1'b1;
    core_in  = '{write: op[0], addr: l1d_addr_t'(addr), wdata: data,
                 size: acc_size_e'(size[2:0])};
    @(negedge clk);
    core_req    = 1'b0;
    wait_cycles = 0;
    while (core_wait)
    begin
      wait_cycles++;
      @(negedge clk);
    end

    if (op == 0)
    begin
      compare_value("core_out", core_out, exp);
      last_load = exp;
      if (hit)
      begin
        compare_value("core_wait cycles", wait_cycles, 2);
        compare_value("d_req pulses", req_count - pulses_before, 0);
      end
      else
      begin
        compare_value("d_req pulses", req_count - pulses_before, LINE_WORDS);
        line_valid[index] = 1'b1;   // refilled line
        line_tag[index]   = addr[31:10];
      end
    end
    else
    begin
      compare_value("d_req pulses", req_count - pulses_before, 1);
      compare_value("memory word", mem_read(addr[31:2]), exp);
      compare_value("core_out", core_out, last_load);   // last load result still held
    end
    $display("Test %0d %s %h (%s): %s", id, (op == 0) ? "read" : "write", addr,
             hit ? "hit" : "miss", (error_count == errors_before) ? "ok" : "FAILED");
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial
  begin
    clk      = 1'b0;
    rst      = 1'b1;
    core_req = 1'b0;
    core_in  = '0;
    d_wait   = 1'b0;
    d_out    = '0;
    void'($urandom(32'h53aa_ac76));

    for (int i = 0; i < MAX_OPS*OP_FIELDS; i++)
      stim_words[i] = '1;   // all ones id ends the list
    $readmemh("verif/l1d_stim.txt", stim_words);
    while (op_count < MAX_OPS && stim_words[op_count*OP_FIELDS] != '1)
      op_count++;
    cycle_limit = (op_count + 1) * 40;
    for (int i = 0; i < NUM_LINES; i++)
      line_valid[i] = 1'b0;

    repeat (2) @(negedge clk);
    rst = 1'b0;

    // Idle after reset with nothing sent to memory
    repeat (3) @(negedge clk);
    compare_value("core_wait", core_wait, 0);
    compare_value("d_req pulses", req_count, 0);
    compare_value("core_out", core_out, 0);
    $display("Test 0 reset: %s", (error_count == 0) ? "ok" : "FAILED");

    for (int i = 0; i < op_count; i++)
      run_op(i);

    $display("Tests %0d, checks %0d, errors %0d", op_count + 1, check_count, error_count);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* l1d_cache.f */
hw/l1d_geom_pkg.sv
hw/l1d_bus_pkg.sv
hw/l1d_line_store.sv
hw/l1d_store_merge.sv
hw/l1d_mem_seq.sv
hw/l1d_ctrl.sv
hw/l1d_cache.sv
verif/tb_l1d_cache.sv

/* verif/l1d_stim.txt */
// id op addr size data expected
// op 0 read, expected load word; op 1 write, expected memory word after it; size 0/1/2 byte/half/word
00000001 0 00001230 2 00000000 c0de048c
00000002 0 00002244 2 00000000 c0de0891
00000003 0 00003358 2 00000000 c0de0cd6
00000004 0 0000446c 2 00000000 c0de111b
// Hits on the first line
00000005 0 00001238 2 00000000 c0de048e
00000006 0 00001230 2 00000000 c0de048c
// Store hits of each size, each read back
00000007 1 00001231 0 000000a5 c0dea58c
00000008 0 00001230 2 00000000 c0dea58c
00000009 1 00001236 1 0000beef beef048d
0000000a 0 00001234 2 00000000 beef048d
0000000b 1 0000123c 2 12345678 12345678
0000000c 0 0000123c 2 00000000 12345678
0000000d 1 0000123b 0 0000005a 5ade048e
0000000e 0 00001238 2 00000000 5ade048e
// Store misses, no allocate
0000000f 1 00005500 2 cafef00d cafef00d
00000010 0 00005500 2 00000000 cafef00d
00000011 1 00006602 0 00000077 c0771980
00000012 0 00006600 2 00000000 c0771980
// Same index, other tag
00000013 0 00011230 2 00000000 c0de448c
00000014 0 00001230 2 00000000 c0dea58c
00000015 0 00011230 2 00000000 c0de448c
00000016 0 00011234 2 00000000 c0de448d
// Top of the address space
00000017 0 fffffff0 2 00000000 ff21fffc
00000018 0 fffffffc 2 00000000 ff21ffff
